// File: cache_controller.sv
`default_nettype none
`timescale 1ns/1ps

module cache_controller (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire cache_pkg::addr_t   addr,
	input  wire cache_pkg::word_t   data_in,
	input  wire                     rd,
	input  wire                     wr,
	output cache_pkg::word_t        data_out,
	output logic                    done,
	output logic                    stall,
	output logic                    cache_hit,

	output logic                    way0_en,
	output logic                    way0_compare,
	output logic                    way0_write,
	output logic                    way0_valid_in,
	output cache_pkg::tag_t         way0_tag_in,
	output cache_pkg::index_t       way0_index,
	output cache_pkg::offset_t      way0_offset,
	output cache_pkg::word_t        way0_data_in,
	input  wire                     way0_hit,
	input  wire                     way0_dirty,
	input  wire                     way0_valid,
	input  wire cache_pkg::tag_t    way0_tag_out,
	input  wire cache_pkg::word_t   way0_data_out,

	output logic                    way1_en,
	output logic                    way1_compare,
	output logic                    way1_write,
	output logic                    way1_valid_in,
	output cache_pkg::tag_t         way1_tag_in,
	output cache_pkg::index_t       way1_index,
	output cache_pkg::offset_t      way1_offset,
	output cache_pkg::word_t        way1_data_in,
	input  wire                     way1_hit,
	input  wire                     way1_dirty,
	input  wire                     way1_valid,
	input  wire cache_pkg::tag_t    way1_tag_out,
	input  wire cache_pkg::word_t   way1_data_out,

	output logic                    clear,
	output logic                    touch,
	output logic                    touch_way,
	input  wire                     victim,
	output cache_pkg::index_t       lookup_index,

	output cache_pkg::addr_t        mem_addr,
	output cache_pkg::word_t        mem_data_in,
	output logic                    mem_read,
	output logic                    mem_write,
	input  wire cache_pkg::word_t   mem_data_out,
	input  wire                     mem_stall
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::addr_t       req_addr;
	cache_pkg::word_t       req_data;
	cache_pkg::word_t       fill_word;
	cache_pkg::word_t       data_q;
	cache_pkg::word_t       new_word;
	cache_pkg::offset_t     cnt;
	cache_pkg::index_t      sweep_cnt;
	logic                   sweeping;
	logic                   is_read;
	logic                   fill_way;
	logic                   evict_needed;
	logic                   lookup;
	logic                   any_hit;
	logic                   miss_way;
	logic                   miss_dirty;
	logic                   last_word;
	logic                   fill_en;
	cache_pkg::tag_t        victim_tag;

	assign lookup = (state == cache_pkg::COMP_READ) || (state == cache_pkg::COMP_WRITE);
	assign any_hit = way0_hit || way1_hit;
	assign last_word = (cnt == cache_pkg::offset_t'(cache_pkg::BLOCK_WORDS - 1));

	// invalid way first, otherwise the lru way
	assign miss_way = !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : victim);
	assign miss_dirty = miss_way ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);
	assign victim_tag = fill_way ? way1_tag_out : way0_tag_out;

	// both ways see the same address and data, en picks the target
	assign fill_en = (state == cache_pkg::FILL_STORE);
	assign lookup_index = sweeping ? sweep_cnt : req_addr[10:3];
	assign clear = sweeping;

	assign way0_en = lookup || (fill_en && !fill_way);
	assign way1_en = lookup || (fill_en && fill_way);
	assign way0_compare = lookup;
	assign way1_compare = lookup;
	assign way0_write = (state == cache_pkg::COMP_WRITE) || fill_en;
	assign way1_write = (state == cache_pkg::COMP_WRITE) || fill_en;
	assign way0_valid_in = fill_en && last_word;
	assign way1_valid_in = fill_en && last_word;
	assign way0_tag_in = req_addr[15:11];
	assign way1_tag_in = req_addr[15:11];
	assign way0_index = lookup_index;
	assign way1_index = lookup_index;
	assign way0_offset = lookup ? req_addr[2:1] : cnt;
	assign way1_offset = lookup ? req_addr[2:1] : cnt;
	assign way0_data_in = lookup ? req_data : mem_data_out;
	assign way1_data_in = lookup ? req_data : mem_data_out;

	// write-back rebuilds the victim address from its stored tag
	always_comb begin
		case (state)
		cache_pkg::MEM_WRITE: mem_addr = req_addr;
		cache_pkg::EVICT: mem_addr = {victim_tag, req_addr[10:3], cnt, 1'b0};
		default: mem_addr = {req_addr[15:3], cnt, 1'b0};
		endcase
	end

	assign mem_data_in = (state == cache_pkg::MEM_WRITE) ? req_data :
		(fill_way ? way1_data_out : way0_data_out);
	assign mem_write = (state == cache_pkg::MEM_WRITE) || (state == cache_pkg::EVICT);
	assign mem_read = (state == cache_pkg::FILL_REQ);

	assign cache_hit = lookup && any_hit;
	assign done = cache_hit || (fill_en && last_word);
	assign stall = sweeping || (state != cache_pkg::IDLE);
	assign touch = done;
	assign touch_way = lookup ? way1_hit : fill_way;

	// requested word, from the hit way or from the fill stream
	assign new_word = lookup ? (way1_hit ? way1_data_out : way0_data_out) :
		((cnt == req_addr[2:1]) ? mem_data_out : fill_word);
	assign data_out = (done && is_read) ? new_word : data_q;

	always_ff @(posedge clk) begin
		if (state == cache_pkg::IDLE && (rd || wr)) begin
			req_addr <= addr;
			req_data <= data_in;
		end
		if (fill_en && cnt == req_addr[2:1]) begin
			fill_word <= mem_data_out;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cache_pkg::IDLE;
			sweeping <= 1'b1;
			sweep_cnt <= '0;
			cnt <= '0;
			is_read <= 1'b0;
			fill_way <= 1'b0;
			evict_needed <= 1'b0;
			data_q <= '0;
		end else begin
			if (sweeping) begin
				sweep_cnt <= sweep_cnt + 1'b1;
				if (sweep_cnt == cache_pkg::index_t'(cache_pkg::NUM_SETS - 1)) begin
					sweeping <= 1'b0;
				end
			end
			if (done && is_read) begin
				data_q <= new_word;
			end
			case (state)
			cache_pkg::IDLE: begin
				if (!sweeping && rd) begin
					is_read <= 1'b1;
					state <= cache_pkg::COMP_READ;
				end else if (!sweeping && wr) begin
					is_read <= 1'b0;
					state <= cache_pkg::COMP_WRITE;
				end
			end
			cache_pkg::COMP_READ, cache_pkg::COMP_WRITE: begin
				cnt <= '0;
				fill_way <= miss_way;
				evict_needed <= miss_dirty;
				if (any_hit) begin
					state <= cache_pkg::IDLE;
				end else if (state == cache_pkg::COMP_WRITE) begin
					// write miss goes to memory before the allocate
					state <= cache_pkg::MEM_WRITE;
				end else begin
					state <= miss_dirty ? cache_pkg::EVICT : cache_pkg::FILL_REQ;
				end
			end
			cache_pkg::MEM_WRITE: state <= cache_pkg::MEM_WRITE_WAIT;
			cache_pkg::MEM_WRITE_WAIT: begin
				if (!mem_stall) begin
					state <= evict_needed ? cache_pkg::EVICT : cache_pkg::FILL_REQ;
				end
			end
			cache_pkg::EVICT: state <= cache_pkg::EVICT_WAIT;
			cache_pkg::EVICT_WAIT: begin
				if (!mem_stall) begin
					cnt <= cnt + 1'b1;
					state <= last_word ? cache_pkg::FILL_REQ : cache_pkg::EVICT;
				end
			end
			cache_pkg::FILL_REQ: state <= cache_pkg::FILL_WAIT;
			cache_pkg::FILL_WAIT: begin
				if (!mem_stall) begin
					state <= cache_pkg::FILL_STORE;
				end
			end
			cache_pkg::FILL_STORE: begin
				cnt <= cnt + 1'b1;
				state <= last_word ? cache_pkg::IDLE : cache_pkg::FILL_REQ;
			end
			default: state <= cache_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address and data words
	typedef logic [15:0] addr_t;
	typedef logic [15:0] word_t;

	// address fields: tag 15..11, index 10..3, word 2..1
	typedef logic [4:0] tag_t;
	typedef logic [7:0] index_t;
	typedef logic [1:0] offset_t;

	localparam int NUM_SETS = 256;
	localparam int BLOCK_WORDS = 4;

	// cycles that mem_stall stays high after a strobe
	localparam int MEM_LATENCY = 4;
	typedef logic [$clog2(MEM_LATENCY + 1) - 1:0] lat_cnt_t;

	typedef enum logic [3:0] {
		IDLE,
		COMP_READ,
		COMP_WRITE,
		MEM_WRITE,
		MEM_WRITE_WAIT,
		EVICT,
		EVICT_WAIT,
		FILL_REQ,
		FILL_WAIT,
		FILL_STORE
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: cache_top.sv
`default_nettype none
`timescale 1ns/1ps

module cache_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire cache_pkg::addr_t addr,
	input  wire cache_pkg::word_t data_in,
	input  wire                   rd,
	input  wire                   wr,
	output cache_pkg::word_t      data_out,
	output logic                  done,
	output logic                  stall,
	output logic                  cache_hit
);

	logic way0_en, way0_compare, way0_write, way0_valid_in;
	logic way0_hit, way0_dirty, way0_valid;
	cache_pkg::tag_t    way0_tag_in, way0_tag_out;
	cache_pkg::index_t  way0_index;
	cache_pkg::offset_t way0_offset;
	cache_pkg::word_t   way0_data_in, way0_data_out;

	logic way1_en, way1_compare, way1_write, way1_valid_in;
	logic way1_hit, way1_dirty, way1_valid;
	cache_pkg::tag_t    way1_tag_in, way1_tag_out;
	cache_pkg::index_t  way1_index;
	cache_pkg::offset_t way1_offset;
	cache_pkg::word_t   way1_data_in, way1_data_out;

	logic clear, touch, touch_way, victim;
	cache_pkg::index_t lookup_index;

	cache_pkg::addr_t mem_addr;
	cache_pkg::word_t mem_data_in, mem_data_out;
	logic mem_read, mem_write, mem_stall;

	cache_controller u_ctrl (.*);

	cache_way u_way0 (
		.clk(clk), .rst_n(rst_n), .en(way0_en), .compare(way0_compare),
		.write(way0_write), .valid_in(way0_valid_in), .tag_in(way0_tag_in),
		.index(way0_index), .offset(way0_offset), .data_in(way0_data_in),
		.clear(clear), .hit(way0_hit), .dirty(way0_dirty), .valid(way0_valid),
		.tag_out(way0_tag_out), .data_out(way0_data_out)
	);

	cache_way u_way1 (
		.clk(clk), .rst_n(rst_n), .en(way1_en), .compare(way1_compare),
		.write(way1_write), .valid_in(way1_valid_in), .tag_in(way1_tag_in),
		.index(way1_index), .offset(way1_offset), .data_in(way1_data_in),
		.clear(clear), .hit(way1_hit), .dirty(way1_dirty), .valid(way1_valid),
		.tag_out(way1_tag_out), .data_out(way1_data_out)
	);

	victim_select u_victim (
		.clk(clk), .rst_n(rst_n), .clear(clear), .touch(touch),
		.touch_way(touch_way), .index(lookup_index), .victim(victim)
	);

	main_memory u_mem (.*);

endmodule

`default_nettype wire

// File: cache_way.sv
`default_nettype none
`timescale 1ns/1ps

module cache_way (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     en,
	input  wire                     compare,
	input  wire                     write,
	input  wire                     valid_in,
	input  wire cache_pkg::tag_t    tag_in,
	input  wire cache_pkg::index_t  index,
	input  wire cache_pkg::offset_t offset,
	input  wire cache_pkg::word_t   data_in,
	input  wire                     clear,
	output logic                    hit,
	output logic                    dirty,
	output logic                    valid,
	output cache_pkg::tag_t         tag_out,
	output cache_pkg::word_t        data_out
);

	cache_pkg::tag_t  tag_mem   [cache_pkg::NUM_SETS];
	cache_pkg::word_t data_mem  [cache_pkg::NUM_SETS][cache_pkg::BLOCK_WORDS];
	logic             valid_mem [cache_pkg::NUM_SETS];
	logic             dirty_mem [cache_pkg::NUM_SETS];
	logic             tag_match;
	logic             word_we;

	// all reads are combinational from the indexed set
	assign tag_out = tag_mem[index];
	assign valid = valid_mem[index];
	assign dirty = dirty_mem[index];
	assign data_out = data_mem[index][offset];

	assign tag_match = valid && (tag_out == tag_in);
	assign hit = en && compare && tag_match;

	// compare-write only lands on a match, fill-write always does
	assign word_we = en && write && (!compare || tag_match);

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			valid_mem[index] <= 1'b0;
			dirty_mem[index] <= 1'b0;
		end else if (en && write) begin
			if (!compare) begin
				valid_mem[index] <= valid_in;
				dirty_mem[index] <= 1'b0;
			end else if (tag_match) begin
				dirty_mem[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_we) begin
			data_mem[index][offset] <= data_in;
		end
		// tag only changes on a block fill
		if (en && write && !compare) begin
			tag_mem[index] <= tag_in;
		end
	end

endmodule

`default_nettype wire

// File: list.f
cache_pkg.sv
cache_way.sv
victim_select.sv
main_memory.sv
cache_controller.sv
cache_top.sv
tb_cache_top.sv

// File: main_memory.sv
`default_nettype none
`timescale 1ns/1ps

module main_memory (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire cache_pkg::addr_t mem_addr,
	input  wire cache_pkg::word_t mem_data_in,
	input  wire                   mem_read,
	input  wire                   mem_write,
	output cache_pkg::word_t      mem_data_out,
	output logic                  mem_stall
);

	// word addressed, bit 0 of the address is always zero
	cache_pkg::word_t mem [1 << ($bits(cache_pkg::addr_t) - 1)];

	cache_pkg::lat_cnt_t                    lat_cnt;
	logic                                   rd_pending;
	logic [$bits(cache_pkg::addr_t) - 2:0]  rd_word;

	// each word starts out holding its own word index
	initial begin
		for (int i = 0; i < $size(mem); i++) begin
			mem[i] = cache_pkg::word_t'(i);
		end
	end

	assign mem_stall = (lat_cnt != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lat_cnt <= '0;
			rd_pending <= 1'b0;
		end else if (mem_read || mem_write) begin
			lat_cnt <= cache_pkg::lat_cnt_t'(cache_pkg::MEM_LATENCY);
			rd_pending <= mem_read;
		end else if (mem_stall) begin
			lat_cnt <= lat_cnt - 1'b1;
			if (lat_cnt == cache_pkg::lat_cnt_t'(1)) begin
				rd_pending <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (mem_write) begin
			mem[mem_addr[15:1]] <= mem_data_in;
		end
	end

	// read data shows up as mem_stall falls, then holds
	always_ff @(posedge clk) begin
		if (mem_read) begin
			rd_word <= mem_addr[15:1];
		end
		if (rd_pending && lat_cnt == cache_pkg::lat_cnt_t'(1)) begin
			mem_data_out <= mem[rd_word];
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cache_top -f list.f -o sim_cache
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_cache 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

// File: tb_cache_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cache_top;

	typedef enum logic [1:0] {op_read, op_write, op_peek} op_t;

	logic             clk;
	logic             rst_n;
	cache_pkg::addr_t addr;
	cache_pkg::word_t data_in;
	logic             rd;
	logic             wr;
	cache_pkg::word_t data_out;
	logic             done;
	logic             stall;
	logic             cache_hit;

	// one table entry per request or memory peek
	op_t              ops [$];
	cache_pkg::addr_t op_addr [$];
	cache_pkg::word_t op_data [$];
	cache_pkg::word_t op_expect [$];
	logic             op_hit [$];

	int requests = 0;
	int done_count = 0;

	cache_top uut (
		.clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("error at %0d ns: %s is 0x%h, expected 0x%h",
				$time, name, actual, expected));
		end
	endtask

	// word address from tag, set and word in block
	function automatic cache_pkg::addr_t blk_addr(input int tag, input int set, input int word);
		blk_addr = {cache_pkg::tag_t'(tag), cache_pkg::index_t'(set),
			cache_pkg::offset_t'(word), 1'b0};
	endfunction

	// memory starts with each word holding its own word index
	function automatic cache_pkg::word_t reset_word(input cache_pkg::addr_t a);
		reset_word = {1'b0, a[15:1]};
	endfunction

	task automatic add_entry(input op_t op, input cache_pkg::addr_t a, input cache_pkg::word_t d,
		input cache_pkg::word_t exp_d, input logic exp_h);
		ops.push_back(op);
		op_addr.push_back(a);
		op_data.push_back(d);
		op_expect.push_back(exp_d);
		op_hit.push_back(exp_h);
	endtask

	// blocks A to D share set 5 and one more block sits alone in set 9
	task automatic build_table();
		cache_pkg::addr_t a1;
		cache_pkg::addr_t a2;
		cache_pkg::addr_t a3;
		cache_pkg::addr_t b0;
		cache_pkg::addr_t b1;
		cache_pkg::addr_t b3;
		cache_pkg::addr_t c1;
		cache_pkg::addr_t c2;
		cache_pkg::addr_t d0;
		cache_pkg::addr_t d3;
		a1 = blk_addr(1, 5, 1);
		a2 = blk_addr(1, 5, 2);
		a3 = blk_addr(1, 5, 3);
		b0 = blk_addr(2, 5, 0);
		b1 = blk_addr(2, 5, 1);
		b3 = blk_addr(2, 5, 3);
		c1 = blk_addr(3, 5, 1);
		c2 = blk_addr(3, 5, 2);
		d0 = blk_addr(4, 5, 0);
		d3 = blk_addr(4, 5, 3);
		// cold miss fills way0, then a hit in the same block
		add_entry(op_read, a1, 16'h0, reset_word(a1), 1'b0);
		add_entry(op_read, a3, 16'h0, reset_word(a3), 1'b1);
		// a write hit leaves the old word in memory
		add_entry(op_write, a2, 16'hbeef, 16'h0, 1'b1);
		add_entry(op_read, a2, 16'h0, 16'hbeef, 1'b1);
		add_entry(op_peek, a2, 16'h0, reset_word(a2), 1'b0);
		// write miss lands in memory, then allocates way1
		add_entry(op_write, b0, 16'h1234, 16'h0, 1'b0);
		add_entry(op_peek, b0, 16'h0, 16'h1234, 1'b0);
		add_entry(op_read, b0, 16'h0, 16'h1234, 1'b1);
		// A is lru and dirty, C pushes it out
		add_entry(op_read, c1, 16'h0, reset_word(c1), 1'b0);
		add_entry(op_peek, a2, 16'h0, 16'hbeef, 1'b0);
		add_entry(op_read, b3, 16'h0, reset_word(b3), 1'b1);
		// C is lru now, A comes back with the written word
		add_entry(op_read, a2, 16'h0, 16'hbeef, 1'b0);
		add_entry(op_read, b0, 16'h0, 16'h1234, 1'b1);
		add_entry(op_read, c1, 16'h0, reset_word(c1), 1'b0);
		// dirty B becomes lru and a write miss to D writes it back
		add_entry(op_write, b1, 16'h5a5a, 16'h0, 1'b1);
		add_entry(op_read, c2, 16'h0, reset_word(c2), 1'b1);
		add_entry(op_write, d3, 16'hc0de, 16'h0, 1'b0);
		add_entry(op_read, d3, 16'h0, 16'hc0de, 1'b1);
		add_entry(op_read, b1, 16'h0, 16'h5a5a, 1'b0);
		add_entry(op_read, d0, 16'h0, reset_word(d0), 1'b1);
		// other sets are not disturbed
		add_entry(op_read, blk_addr(1, 9, 2), 16'h0, reset_word(blk_addr(1, 9, 2)), 1'b0);
		add_entry(op_read, blk_addr(1, 9, 0), 16'h0, reset_word(blk_addr(1, 9, 0)), 1'b1);
	endtask

	task automatic run_entry(input int n);
		int cycles;
		cycles = 0;
		if (ops[n] == op_peek) begin
			check_value("memory word", uut.u_mem.mem[op_addr[n][15:1]], op_expect[n]);
		end else begin
			addr = op_addr[n];
			data_in = op_data[n];
			rd = (ops[n] == op_read);
			wr = (ops[n] == op_write);
			requests++;
			@(negedge clk);
			rd = 1'b0;
			wr = 1'b0;
			cycles = 1;
			while (!done) begin
				check_value("stall", stall, 1'b1);
				@(negedge clk);
				cycles++;
			end
			check_value("cache_hit", cache_hit, op_hit[n]);
			if (op_hit[n]) begin
				check_value("hit latency", 16'(cycles), 16'd1);
			end
			if (ops[n] == op_read) begin
				check_value("data_out", data_out, op_expect[n]);
			end
			// done is a single pulse and the cache is ready again
			@(negedge clk);
			check_value("done", done, 1'b0);
			check_value("stall", stall, 1'b0);
			if (ops[n] == op_read) begin
				check_value("data_out", data_out, op_expect[n]);
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && cache_hit && !done) begin
			fail_run($sformatf("cache_hit was high without done at %0d ns", $time));
		end
		if (rst_n && done) begin
			done_count = done_count + 1;
		end
	end

	// reset, sweep, then up to 60 cycles for each table entry
	initial begin
		int limit;
		#1;
		limit = 16 + cache_pkg::NUM_SETS + 8 + ops.size() * 60;
		#(limit * 100);
		fail_run($sformatf("timeout: the test did not finish within %0d cycles", limit));
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		build_table();
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		// the tag sweep keeps stall high
		while (stall) begin
			@(negedge clk);
		end
		check_value("done", done, 1'b0);
		check_value("cache_hit", cache_hit, 1'b0);
		check_value("data_out", data_out, 16'h0);
		for (int n = 0; n < ops.size(); n++) begin
			run_entry(n);
		end
		@(posedge clk);
		check_value("done count", 16'(done_count), 16'(requests));
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: victim_select.sv
`default_nettype none
`timescale 1ns/1ps

module victim_select (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    clear,
	input  wire                    touch,
	input  wire                    touch_way,
	input  wire cache_pkg::index_t index,
	output logic                   victim
);

	// one bit per set, names the least recently used way
	logic lru_mem [cache_pkg::NUM_SETS];

	assign victim = lru_mem[index];

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			lru_mem[index] <= 1'b0;
		end else if (touch) begin
			// the other way becomes the replacement candidate
			lru_mem[index] <= ~touch_way;
		end
	end

endmodule

`default_nettype wire
